// File: vga_mode_pkg.sv
// vga 640x480 mode constants
package vga_mode_pkg;

  // horizontal timing in pixel clocks
  localparam int h_visible = 640;
  localparam int h_front   = 16;
  localparam int h_sync    = 96;
  localparam int h_back    = 48;
  localparam int h_total   = h_visible + h_front + h_sync + h_back;

  // vertical timing in lines
  localparam int v_visible = 480;
  localparam int v_front   = 10;
  localparam int v_sync    = 2;
  localparam int v_back    = 33;
  localparam int v_total   = v_visible + v_front + v_sync + v_back;

  // sync low from start up to, not including, end
  localparam int h_sync_start = h_visible + h_front;
  localparam int h_sync_end   = h_sync_start + h_sync;
  localparam int v_sync_start = v_visible + v_front;
  localparam int v_sync_end   = v_sync_start + v_sync;

  // counter widths, 800 and 525 both fit in 10 bits
  typedef logic [9:0] h_count_t;
  typedef logic [9:0] v_count_t;

  // counters to pins: framebuffer read stage plus output register
  localparam int scan_latency = 2;

endpackage

// File: plot_pkg.sv
// framebuffer and plotting types
package plot_pkg;

  // striping over two banks by the low pixel address bit
  localparam int num_banks   = 2;
  localparam int pixel_count = 307200;
  localparam int bank_depth  = pixel_count / num_banks;

  // linear pixel index, y * 640 + x
  typedef logic [18:0] pixel_addr_t;
  // index inside one bank, pixel index >> 1
  typedef logic [17:0] bank_addr_t;
  typedef logic bank_sel_t;

  typedef logic [3:0] color_t;

  localparam color_t color_on = 4'hf;

  typedef struct packed {
    logic [3:0] rsvd;
    color_t     red;
    color_t     grn;
    color_t     blu;
  } pixel_t;

  // raw view for clearing, pix view for plotting and scanout
  typedef union packed {
    logic [15:0] raw;
    pixel_t      pix;
  } fb_word_u;

  typedef logic [9:0] adc_sample_t;

  // adc to screen scaling, 1023 maps to 639 and 479
  localparam int x_scale_mul   = 5;
  localparam int x_scale_shift = 3;
  localparam int y_scale_mul   = 15;
  localparam int y_scale_shift = 5;

endpackage

// File: vga_timing.sv
// vga raster timing generator
module vga_timing (
  input  logic                   pixel_clk,
  input  logic                   rst_n,
  output vga_mode_pkg::h_count_t h_count,
  output vga_mode_pkg::v_count_t v_count,
  output logic                   visible,
  output logic                   hsync,
  output logic                   vsync
);

  logic h_last;
  logic v_last;

  assign h_last = (h_count == vga_mode_pkg::h_count_t'(vga_mode_pkg::h_total - 1));
  assign v_last = (v_count == vga_mode_pkg::v_count_t'(vga_mode_pkg::v_total - 1));

  // free running, no stall
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else begin
      if (h_last) begin
        h_count <= '0;
        if (v_last) begin
          v_count <= '0;
        end else begin
          v_count <= v_count + 1'b1;
        end
      end else begin
        h_count <= h_count + 1'b1;
      end
    end
  end

  assign visible = (h_count < vga_mode_pkg::h_count_t'(vga_mode_pkg::h_visible)) &&
                   (v_count < vga_mode_pkg::v_count_t'(vga_mode_pkg::v_visible));

  // active low syncs
  assign hsync = !((h_count >= vga_mode_pkg::h_count_t'(vga_mode_pkg::h_sync_start)) &&
                   (h_count <  vga_mode_pkg::h_count_t'(vga_mode_pkg::h_sync_end)));

  assign vsync = !((v_count >= vga_mode_pkg::v_count_t'(vga_mode_pkg::v_sync_start)) &&
                   (v_count <  vga_mode_pkg::v_count_t'(vga_mode_pkg::v_sync_end)));

endmodule

// File: adc_sampler.sv
// adc sample plotter and frame clear
module adc_sampler (
  input  logic                  pixel_clk,
  input  logic                  rst_n,
  input  plot_pkg::adc_sample_t adc_x,
  input  plot_pkg::adc_sample_t adc_y,
  input  logic                  adc_red,
  input  logic                  adc_grn,
  input  logic                  adc_blu,
  input  logic                  adc_strobe,
  input  logic                  clear,
  output logic                  busy,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output plot_pkg::pixel_addr_t wb_adr,
  output plot_pkg::fb_word_u    wb_dat,
  input  logic                  wb_ack
);

  logic [12:0]            x_prod;
  logic [13:0]            y_prod;
  vga_mode_pkg::h_count_t x_scr;
  vga_mode_pkg::v_count_t y_scr;
  plot_pkg::pixel_addr_t  plot_adr;
  plot_pkg::pixel_t       plot_pix;
  logic                   sweep;
  logic                   last_adr;

  // scale to screen, products sized to hold 1023 * mul
  assign x_prod = 13'(adc_x) * 13'(plot_pkg::x_scale_mul);
  assign y_prod = 14'(adc_y) * 14'(plot_pkg::y_scale_mul);
  assign x_scr  = vga_mode_pkg::h_count_t'(x_prod >> plot_pkg::x_scale_shift);
  assign y_scr  = vga_mode_pkg::v_count_t'(y_prod >> plot_pkg::y_scale_shift);

  assign plot_adr = plot_pkg::pixel_addr_t'(y_scr) *
                    plot_pkg::pixel_addr_t'(vga_mode_pkg::h_visible) +
                    plot_pkg::pixel_addr_t'(x_scr);

  // each colour bit becomes full scale or off
  always_comb begin
    plot_pix.rsvd = '0;
    plot_pix.red  = adc_red ? plot_pkg::color_on : '0;
    plot_pix.grn  = adc_grn ? plot_pkg::color_on : '0;
    plot_pix.blu  = adc_blu ? plot_pkg::color_on : '0;
  end

  assign last_adr = (wb_adr == plot_pkg::pixel_addr_t'(plot_pkg::pixel_count - 1));
  assign wb_we    = 1'b1;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      sweep  <= 1'b0;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else if (!busy) begin
      // clear wins over a strobe in the same cycle
      if (clear) begin
        busy       <= 1'b1;
        sweep      <= 1'b1;
        wb_cyc     <= 1'b1;
        wb_stb     <= 1'b1;
        wb_adr     <= '0;
        wb_dat.raw <= '0;
      end else if (adc_strobe) begin
        busy       <= 1'b1;
        sweep      <= 1'b0;
        wb_cyc     <= 1'b1;
        wb_stb     <= 1'b1;
        wb_adr     <= plot_adr;
        wb_dat.pix <= plot_pix;
      end
    end else if (wb_stb) begin
      if (wb_ack) begin
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        if (!sweep || last_adr) begin
          busy  <= 1'b0;
          sweep <= 1'b0;
        end else begin
          wb_adr <= wb_adr + 1'b1;
        end
      end
    end else begin
      // gap cycle between sweep writes
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
    end
  end

endmodule

// File: striped_framebuffer.sv
// two bank striped framebuffer
module striped_framebuffer (
  input  logic                   pixel_clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  plot_pkg::pixel_addr_t  wb_adr,
  input  plot_pkg::fb_word_u     wb_dat,
  output logic                   wb_ack,
  input  logic                   rd_en,
  input  vga_mode_pkg::h_count_t h_count,
  input  vga_mode_pkg::v_count_t v_count,
  output plot_pkg::fb_word_u     rd_word
);

  plot_pkg::pixel_addr_t           rd_adr;
  plot_pkg::bank_addr_t            rd_bank_adr;
  plot_pkg::bank_sel_t             rd_sel;
  plot_pkg::bank_sel_t             rd_sel_q;
  plot_pkg::bank_addr_t            wr_bank_adr;
  plot_pkg::bank_sel_t             wr_sel;
  logic                            wr_req;
  logic [plot_pkg::num_banks-1:0]  bank_re;
  logic [plot_pkg::num_banks-1:0]  bank_we;
  plot_pkg::fb_word_u              bank_q [plot_pkg::num_banks];

  // scanout address straight from the raster counters
  assign rd_adr = plot_pkg::pixel_addr_t'(v_count) *
                  plot_pkg::pixel_addr_t'(vga_mode_pkg::h_visible) +
                  plot_pkg::pixel_addr_t'(h_count);

  assign rd_sel      = rd_adr[0];
  assign rd_bank_adr = plot_pkg::bank_addr_t'(rd_adr >> 1);

  assign wr_req      = wb_cyc && wb_stb && wb_we;
  assign wr_sel      = wb_adr[0];
  assign wr_bank_adr = plot_pkg::bank_addr_t'(wb_adr >> 1);

  for (genvar b = 0; b < plot_pkg::num_banks; b++) begin : g_bank
    logic [15:0] mem [plot_pkg::bank_depth];

    // read always owns its bank, a write waits for a free cycle
    assign bank_re[b] = rd_en && (rd_sel == plot_pkg::bank_sel_t'(b));
    assign bank_we[b] = wr_req && (wr_sel == plot_pkg::bank_sel_t'(b)) && !bank_re[b];

    always_ff @(posedge pixel_clk) begin
      if (bank_we[b]) begin
        mem[wr_bank_adr] <= wb_dat.raw;
      end
      if (bank_re[b]) begin
        bank_q[b].raw <= mem[rd_bank_adr];
      end
    end
  end

  // ack in the same cycle as the bank write
  assign wb_ack = |bank_we;

  // remembers which bank answered the last read
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      rd_sel_q <= 1'b0;
    end else if (rd_en) begin
      rd_sel_q <= rd_sel;
    end
  end

  assign rd_word = bank_q[rd_sel_q];

endmodule

// File: vga_scanout.sv
// vga output stage
module vga_scanout (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               visible,
  input  logic               hsync,
  input  logic               vsync,
  input  plot_pkg::fb_word_u rd_word,
  output plot_pkg::color_t   vga_red,
  output plot_pkg::color_t   vga_grn,
  output plot_pkg::color_t   vga_blu,
  output logic               vga_hsync,
  output logic               vga_vsync
);

  logic [vga_mode_pkg::scan_latency-1:0] hsync_pipe;
  logic [vga_mode_pkg::scan_latency-1:0] vsync_pipe;
  logic                                  visible_d;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      hsync_pipe <= '1;
      vsync_pipe <= '1;
      visible_d  <= 1'b0;
      vga_red    <= '0;
      vga_grn    <= '0;
      vga_blu    <= '0;
    end else begin
      hsync_pipe <= {hsync_pipe[vga_mode_pkg::scan_latency-2:0], hsync};
      vsync_pipe <= {vsync_pipe[vga_mode_pkg::scan_latency-2:0], vsync};

      // lines up with rd_word, one read cycle behind the counters
      visible_d <= visible;

      // black during blanking
      if (visible_d) begin
        vga_red <= rd_word.pix.red;
        vga_grn <= rd_word.pix.grn;
        vga_blu <= rd_word.pix.blu;
      end else begin
        vga_red <= '0;
        vga_grn <= '0;
        vga_blu <= '0;
      end
    end
  end

  assign vga_hsync = hsync_pipe[vga_mode_pkg::scan_latency-1];
  assign vga_vsync = vsync_pipe[vga_mode_pkg::scan_latency-1];

endmodule

// File: adc_display_top.sv
// adc xy display top level
module adc_display_top (
  input  logic                  pixel_clk,
  input  logic                  rst_n,
  input  plot_pkg::adc_sample_t adc_x,
  input  plot_pkg::adc_sample_t adc_y,
  input  logic                  adc_red,
  input  logic                  adc_grn,
  input  logic                  adc_blu,
  input  logic                  adc_strobe,
  input  logic                  clear,
  output plot_pkg::color_t      vga_red,
  output plot_pkg::color_t      vga_grn,
  output plot_pkg::color_t      vga_blu,
  output logic                  vga_hsync,
  output logic                  vga_vsync,
  output logic                  busy
);

  vga_mode_pkg::h_count_t h_count;
  vga_mode_pkg::v_count_t v_count;
  logic                   visible;
  logic                   hsync;
  logic                   vsync;
  plot_pkg::fb_word_u     rd_word;

  // plotting write bus
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  plot_pkg::pixel_addr_t  wb_adr;
  plot_pkg::fb_word_u     wb_dat;
  logic                   wb_ack;

  vga_timing vga_timing_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .h_count  (h_count),
    .v_count  (v_count),
    .visible  (visible),
    .hsync    (hsync),
    .vsync    (vsync)
  );

  adc_sampler adc_sampler_i (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .adc_x     (adc_x),
    .adc_y     (adc_y),
    .adc_red   (adc_red),
    .adc_grn   (adc_grn),
    .adc_blu   (adc_blu),
    .adc_strobe(adc_strobe),
    .clear     (clear),
    .busy      (busy),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat    (wb_dat),
    .wb_ack    (wb_ack)
  );

  striped_framebuffer striped_framebuffer_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat   (wb_dat),
    .wb_ack   (wb_ack),
    .rd_en    (visible),
    .h_count  (h_count),
    .v_count  (v_count),
    .rd_word  (rd_word)
  );

  vga_scanout vga_scanout_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .visible  (visible),
    .hsync    (hsync),
    .vsync    (vsync),
    .rd_word  (rd_word),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

endmodule

// File: adc_display_assert.sv
// wishbone and sync checks
module adc_display_assert (
  input logic                  pixel_clk,
  input logic                  rst_n,
  input logic                  wb_stb,
  input plot_pkg::pixel_addr_t wb_adr,
  input logic                  wb_ack,
  input logic                  hsync
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned low_len;

  // length of the current hsync low pulse
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      low_len <= 0;
    end else if (!hsync) begin
      low_len <= low_len + 1;
    end else begin
      low_len <= 0;
    end
  end

  // master drops the strobe right after ack, so ack is one cycle wide
  ack_single_pulse: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    wb_ack |=> (!wb_stb && !wb_ack))
    else $error("wb_stb or wb_ack still high in the cycle after wb_ack");

  stb_held_until_ack: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else $error("wb_stb or wb_adr changed before wb_ack");

  hsync_pulse_width: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    $rose(hsync) |-> (low_len == vga_mode_pkg::h_sync))
    else $error("hsync low pulse has wrong width");

endmodule

bind adc_display_top adc_display_assert adc_display_assert_i (
  .pixel_clk(pixel_clk),
  .rst_n    (rst_n),
  .wb_stb   (wb_stb),
  .wb_adr   (wb_adr),
  .wb_ack   (wb_ack),
  .hsync    (vga_hsync)
);

// File: adc_display_tb.sv
// adc xy display testbench
module adc_display_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam longint frame_cycles = vga_mode_pkg::h_total * vga_mode_pkg::v_total;
  localparam longint clk_period = 8;
  localparam longint watchdog_frames = 10;
  localparam int max_caps = 8;

  logic                  pixel_clk;
  logic                  rst_n;
  plot_pkg::adc_sample_t adc_x;
  plot_pkg::adc_sample_t adc_y;
  logic                  adc_red;
  logic                  adc_grn;
  logic                  adc_blu;
  logic                  adc_strobe;
  logic                  clear;
  plot_pkg::color_t      vga_red;
  plot_pkg::color_t      vga_grn;
  plot_pkg::color_t      vga_blu;
  logic                  vga_hsync;
  logic                  vga_vsync;
  logic                  busy;

  int errors;
  int checks;
  logic [31:0] rng;

  // monitor state
  logic prev_hs;
  logic prev_vs;
  bit   frame_seen;
  int   col_cnt;
  int   line_cnt;
  int   cur_col;
  int   cur_row;
  bit   blank_en;
  int   blank_viol;

  // capture requests
  int               cap_x [max_caps];
  int               cap_y [max_caps];
  plot_pkg::color_t cap_r [max_caps];
  plot_pkg::color_t cap_g [max_caps];
  plot_pkg::color_t cap_b [max_caps];
  bit               cap_hit [max_caps];
  int               cap_n;
  int               cap_hits;
  bit               cap_active;

  adc_display_top adc_display_top_i (.*);

  always #(clk_period / 2) pixel_clk = ~pixel_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // screen position from the adc scaling rule
  function automatic int scale_x(input int a);
    return (a * 5) >> 3;
  endfunction

  function automatic int scale_y(input int a);
    return (a * 15) >> 5;
  endfunction

  task automatic check_color(input string name, input plot_pkg::color_t exp,
                             input plot_pkg::color_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error @%0t: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error @%0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  // row and column of the pixel now on the pins, from the syncs
  always @(negedge pixel_clk) begin
    if (prev_vs === 1'b0 && vga_vsync === 1'b1) begin
      line_cnt = 0;
      frame_seen = 1;
    end
    if (prev_hs === 1'b0 && vga_hsync === 1'b1) begin
      col_cnt = 0;
      line_cnt++;
    end else begin
      col_cnt++;
    end
    prev_hs = vga_hsync;
    prev_vs = vga_vsync;
    cur_col = col_cnt - vga_mode_pkg::h_back;
    cur_row = line_cnt - vga_mode_pkg::v_back;
    if (frame_seen && blank_en) begin
      if ((cur_col < 0 || cur_col >= vga_mode_pkg::h_visible ||
           cur_row < 0 || cur_row >= vga_mode_pkg::v_visible) &&
          (vga_red != 0 || vga_grn != 0 || vga_blu != 0)) begin
        blank_viol++;
      end
    end
    if (frame_seen && cap_active) begin
      for (int i = 0; i < cap_n; i++) begin
        if (!cap_hit[i] && cur_col == cap_x[i] && cur_row == cap_y[i]) begin
          cap_r[i] = vga_red;
          cap_g[i] = vga_grn;
          cap_b[i] = vga_blu;
          cap_hit[i] = 1;
          cap_hits++;
        end
      end
    end
  end

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    @(negedge pixel_clk);
    while (busy && n < limit) begin
      @(negedge pixel_clk);
      n++;
    end
    if (busy) begin
      errors++;
      $display("busy did not fall within %0d cycles at %0t", limit, $time);
    end
  endtask

  task automatic plot_sample(input int ax, input int ay, input bit r, input bit g,
                             input bit b);
    @(posedge pixel_clk);
    #1;
    adc_x = plot_pkg::adc_sample_t'(ax);
    adc_y = plot_pkg::adc_sample_t'(ay);
    adc_red = r;
    adc_grn = g;
    adc_blu = b;
    adc_strobe = 1;
    @(posedge pixel_clk);
    #1;
    adc_strobe = 0;
    wait_idle(1000);
  endtask

  task automatic clear_frame();
    @(posedge pixel_clk);
    #1;
    clear = 1;
    @(posedge pixel_clk);
    #1;
    clear = 0;
    wait_idle(4 * plot_pkg::pixel_count);
  endtask

  task automatic add_capture(input int x, input int y);
    cap_x[cap_n] = x;
    cap_y[cap_n] = y;
    cap_hit[cap_n] = 0;
    cap_n++;
  endtask

  // guard cycles let the last write reach the scanout pipeline
  task automatic capture_pixels();
    repeat (3) @(posedge pixel_clk);
    cap_hits = 0;
    cap_active = 1;
    while (cap_hits < cap_n) @(negedge pixel_clk);
    cap_active = 0;
  endtask

  task automatic expect_pixel(input int i, input plot_pkg::color_t r,
                              input plot_pkg::color_t g, input plot_pkg::color_t b);
    check_color($sformatf("vga_red(%0d,%0d)", cap_x[i], cap_y[i]), r, cap_r[i]);
    check_color($sformatf("vga_grn(%0d,%0d)", cap_x[i], cap_y[i]), g, cap_g[i]);
    check_color($sformatf("vga_blu(%0d,%0d)", cap_x[i], cap_y[i]), b, cap_b[i]);
  endtask

  task automatic report_result(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic measure_sync_timing();
    int e;
    int low;
    int period;
    e = errors;
    @(negedge vga_hsync);
    low = 0;
    period = 0;
    @(negedge pixel_clk);
    while (!vga_hsync) begin
      low++;
      period++;
      @(negedge pixel_clk);
    end
    while (vga_hsync) begin
      period++;
      @(negedge pixel_clk);
    end
    check_count("vga_hsync low cycles", vga_mode_pkg::h_sync, low);
    check_count("line period", vga_mode_pkg::h_total, period);
    @(negedge vga_vsync);
    low = 0;
    period = 0;
    @(negedge pixel_clk);
    while (!vga_vsync) begin
      low++;
      period++;
      @(negedge pixel_clk);
    end
    while (vga_vsync) begin
      period++;
      @(negedge pixel_clk);
    end
    check_count("vga_vsync low cycles", vga_mode_pkg::v_sync * vga_mode_pkg::h_total, low);
    check_count("frame period", vga_mode_pkg::v_total * vga_mode_pkg::h_total, period);
    report_result("sync_timing", e);
  endtask

  task automatic plot_single_pixel();
    int e;
    e = errors;
    plot_sample(512, 256, 1, 0, 0);
    cap_n = 0;
    add_capture(scale_x(512), scale_y(256));
    add_capture(scale_x(512) + 1, scale_y(256));
    capture_pixels();
    expect_pixel(0, 4'hf, 4'h0, 4'h0);
    expect_pixel(1, 4'h0, 4'h0, 4'h0);
    report_result("single_plot", e);
  endtask

  task automatic plot_adjacent_banks();
    int e;
    e = errors;
    // scaled x 100 and 101 fall in different banks
    plot_sample(160, 320, 0, 1, 0);
    plot_sample(162, 320, 0, 0, 1);
    cap_n = 0;
    add_capture(scale_x(160), scale_y(320));
    add_capture(scale_x(162), scale_y(320));
    capture_pixels();
    expect_pixel(0, 4'h0, 4'hf, 4'h0);
    expect_pixel(1, 4'h0, 4'h0, 4'hf);
    report_result("striping", e);
  endtask

  task automatic drop_strobe_while_busy();
    int e;
    e = errors;
    @(posedge pixel_clk);
    #1;
    adc_x = 600;
    adc_y = 600;
    adc_red = 0;
    adc_grn = 0;
    adc_blu = 1;
    adc_strobe = 1;
    @(posedge pixel_clk);
    #1;
    check_count("busy", 1, int'(busy));
    adc_x = 700;
    adc_y = 700;
    adc_red = 1;
    adc_blu = 0;
    @(posedge pixel_clk);
    #1;
    adc_strobe = 0;
    wait_idle(1000);
    repeat (4) @(negedge pixel_clk);
    check_count("busy after ignored strobe", 0, int'(busy));
    cap_n = 0;
    add_capture(scale_x(600), scale_y(600));
    add_capture(scale_x(700), scale_y(700));
    capture_pixels();
    expect_pixel(0, 4'h0, 4'h0, 4'hf);
    expect_pixel(1, 4'h0, 4'h0, 4'h0);
    report_result("back_pressure", e);
  endtask

  task automatic erase_plotted_pixels();
    int e;
    int ax;
    int ay;
    e = errors;
    cap_n = 0;
    for (int i = 0; i < 4; i++) begin
      rng = xorshift32(rng);
      ax = int'(rng[9:0]);
      ay = int'(rng[19:10]);
      plot_sample(ax, ay, 1, rng[20], rng[21]);
      add_capture(scale_x(ax), scale_y(ay));
    end
    clear_frame();
    capture_pixels();
    for (int i = 0; i < cap_n; i++) begin
      expect_pixel(i, 4'h0, 4'h0, 4'h0);
    end
    report_result("clear", e);
  endtask

  task automatic watch_blanking();
    int e;
    e = errors;
    plot_sample(1023, 1023, 1, 1, 1);
    cap_n = 0;
    add_capture(639, 479);
    blank_viol = 0;
    fork
      begin
        blank_en = 1;
        repeat (frame_cycles) @(posedge pixel_clk);
        blank_en = 0;
      end
      capture_pixels();
    join
    check_count("nonzero colour cycles in blanking", 0, blank_viol);
    expect_pixel(0, 4'hf, 4'hf, 4'hf);
    report_result("blanking", e);
  endtask

  initial begin
    #(watchdog_frames * frame_cycles * clk_period);
    $display("watchdog expired after %0d frames, run did not finish", watchdog_frames);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    pixel_clk = 0;
    rst_n = 0;
    adc_x = '0;
    adc_y = '0;
    adc_red = 0;
    adc_grn = 0;
    adc_blu = 0;
    adc_strobe = 0;
    clear = 0;
    errors = 0;
    checks = 0;
    rng = 32'd38;
    cap_n = 0;
    cap_active = 0;
    blank_en = 0;
    frame_seen = 0;
    col_cnt = 0;
    line_cnt = 0;
    repeat (3) @(posedge pixel_clk);
    #1;
    rst_n = 1;
    // initial sweep runs while the syncs are measured
    fork
      measure_sync_timing();
      clear_frame();
    join
    plot_single_pixel();
    plot_adjacent_banks();
    drop_strobe_while_busy();
    erase_plotted_pixels();
    watch_blanking();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
vga_mode_pkg.sv
plot_pkg.sv
vga_timing.sv
adc_sampler.sv
striped_framebuffer.sv
vga_scanout.sv
adc_display_top.sv
adc_display_assert.sv
adc_display_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module adc_display_tb -Mdir obj_dir
	out=$$(./obj_dir/Vadc_display_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
